/* barrett_core.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Barrett datapath, q estimate, q*m, subtract, up to two corrections
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module barrett_core (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  barrett_op_if.snk                      op,
  output logic                           res_valid_o,
  output logic [barrett_pkg::DATA_W-1:0] res_o
);

  // Operand delay lines
  logic [barrett_pkg::DATA_W-1:0] x_dly [2*barrett_pkg::MUL_STAGES];  // Aligned to q*m
  logic [barrett_pkg::DATA_W-1:0] m_dly [barrett_pkg::CORE_LAT];      // Last tap matches res_o

  barrett_pkg::prod_u             xmu, qm;
  logic                           xmu_valid, qm_valid;
  logic                           sub_valid_q;
  logic [barrett_pkg::DATA_W-1:0] diff_q;   // x - q*m, below 3m
  logic [barrett_pkg::DATA_W-1:0] m_sub;    // Modulus at correction stage
  logic [barrett_pkg::DATA_W-1:0] two_m;
  logic [barrett_pkg::DATA_W-1:0] corr;

  // x*mu, q is the upper word
  mul_pipe mul_xmu (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (op.valid),
    .a_i     (op.x),
    .b_i     (op.mu),
    .valid_o (xmu_valid),
    .p_o     (xmu)
  );

  // q*m, m taken from delay line at matching depth
  mul_pipe mul_qm (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (xmu_valid),
    .a_i     (xmu.half.hi),
    .b_i     (m_dly[barrett_pkg::MUL_STAGES-1]),
    .valid_o (qm_valid),
    .p_o     (qm)
  );

  // Payload shift registers, no reset
  always_ff @(posedge clk_i) begin
    x_dly[0] <= op.x;
    m_dly[0] <= op.m;
    for (int i = 1; i < 2 * barrett_pkg::MUL_STAGES; i++) x_dly[i] <= x_dly[i-1];
    for (int i = 1; i < barrett_pkg::CORE_LAT; i++) m_dly[i] <= m_dly[i-1];
  end

  // Subtract stage, q*m read through low word
  always_ff @(posedge clk_i) begin
    diff_q <= x_dly[2*barrett_pkg::MUL_STAGES-1] - qm.half.lo;
  end

  // Correction, estimate error is at most two
  assign m_sub = m_dly[barrett_pkg::CORE_LAT-2];
  assign two_m = m_sub << 1;
  always_comb begin
    if (diff_q >= two_m) begin
      corr = diff_q - two_m;
    end else if (diff_q >= m_sub) begin
      corr = diff_q - m_sub;
    end else begin
      corr = diff_q;
    end
  end

  always_ff @(posedge clk_i) begin
    res_o <= corr;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sub_valid_q <= 1'b0;
      res_valid_o <= 1'b0;
    end else begin
      sub_valid_q <= qm_valid;
      res_valid_o <= sub_valid_q;
    end
  end

  // Fully reduced against the modulus that entered with it
  a_res_lt_m: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o |-> (res_o < m_dly[barrett_pkg::CORE_LAT-1]));

endmodule : barrett_core

/* barrett_in_port.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Four-phase operand receiver with in-flight credit count
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module barrett_in_port (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  logic [barrett_pkg::DATA_W-1:0] x_i,
  input  logic [barrett_pkg::DATA_W-1:0] m_i,
  input  logic [barrett_pkg::DATA_W-1:0] mu_i,
  input  logic                           pop_i,  // One result left the FIFO
  output logic                           ack_o,
  barrett_op_if.src                      op
);

  logic [barrett_pkg::CNT_W-1:0] outstanding_q;  // Accepted, not yet popped
  logic                          accept;

  // New request, idle handshake and a free FIFO slot
  assign accept = req_i && !ack_o && (outstanding_q < barrett_pkg::FIFO_DEPTH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o    <= 1'b0;
      op.valid <= 1'b0;
    end else begin
      op.valid <= accept;  // Strobe for exactly one cycle
      if (accept) begin
        ack_o <= 1'b1;
      end else if (ack_o && !req_i) begin
        ack_o <= 1'b0;  // Return to zero phase
      end
    end
  end

  // Credit counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else if (accept && !pop_i) begin
      outstanding_q <= outstanding_q + 1'b1;
    end else if (!accept && pop_i) begin
      outstanding_q <= outstanding_q - 1'b1;
    end
  end

  // Operand capture, stable until next accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op.x  <= x_i;
      op.m  <= m_i;
      op.mu <= mu_i;
    end
  end

  // Ack only drops after producer released req
  a_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(ack_o) |-> !$past(req_i));

endmodule : barrett_in_port

/* barrett_op_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Operand bundle from input side to Barrett core
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface barrett_op_if;

  logic                          valid;  // One-cycle strobe, no ready
  logic [barrett_pkg::DATA_W-1:0] x;      // Dividend
  logic [barrett_pkg::DATA_W-1:0] m;      // Modulus, upper MOD_W bits zero
  logic [barrett_pkg::DATA_W-1:0] mu;     // floor(2^64 / m) from caller

  // Input side drives
  modport src (
    output valid,
    output x,
    output m,
    output mu
  );

  // Core samples
  modport snk (
    input valid,
    input x,
    input m,
    input mu
  );

endinterface : barrett_op_if

/* barrett_out_port.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Result FIFO and four-phase sender toward consumer
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module barrett_out_port (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           res_valid_i,  // Write strobe from core
  input  logic [barrett_pkg::DATA_W-1:0] res_i,
  input  logic                           res_ack_i,
  output logic                           res_req_o,
  output logic [barrett_pkg::DATA_W-1:0] res_o,
  output logic                           pop_o         // Credit return
);

  logic [barrett_pkg::DATA_W-1:0] mem [barrett_pkg::FIFO_DEPTH];
  logic [barrett_pkg::CNT_W-2:0]  wr_ptr_q, rd_ptr_q;  // Wrap at power of two depth
  logic [barrett_pkg::CNT_W-1:0]  fill_q;
  logic                           wait_low_q;  // Ack still high after pop
  logic                           do_pop;

  // Consumer took the head entry
  assign do_pop = res_req_o && res_ack_i;

  always_ff @(posedge clk_i) begin
    if (res_valid_i) begin
      mem[wr_ptr_q] <= res_i;
    end
  end

  // Head entry, rd_ptr only moves when req drops
  assign res_o = mem[rd_ptr_q];

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (res_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (res_valid_i && !do_pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (!res_valid_i && do_pop) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  // Sender FSM: idle, req high, wait for ack low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_req_o  <= 1'b0;
      wait_low_q <= 1'b0;
      pop_o      <= 1'b0;
    end else begin
      pop_o <= do_pop;
      if (do_pop) begin
        res_req_o  <= 1'b0;
        wait_low_q <= 1'b1;
      end else if (wait_low_q) begin
        if (!res_ack_i) wait_low_q <= 1'b0;  // Handshake back to zero
      end else if (!res_req_o && fill_q != '0) begin
        res_req_o <= 1'b1;  // Present head entry
      end
    end
  end

  // Credits keep the core from writing a full FIFO
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_i |-> (fill_q != barrett_pkg::FIFO_DEPTH));

endmodule : barrett_out_port

/* barrett_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Barrett reduction shared widths, depths and product word type
// ~~~~~~~~~~~~~~~~~~~~
package barrett_pkg;

  // Operand and result widths
  localparam int DATA_W = 64;  // x, mu and remainder path
  localparam int MOD_W  = 32;  // Legal modulus range, upper m bits zero

  // Pipeline depths
  localparam int MUL_STAGES = 3;                   // Registers inside mul_pipe
  localparam int CORE_LAT   = 2 * MUL_STAGES + 2;  // Two multipliers, subtract, correct

  // Result buffering and credits
  localparam int CNT_W = 3;  // Holds 0..FIFO_DEPTH
  localparam logic [CNT_W-1:0] FIFO_DEPTH = 3'd4;

  // Full multiplier output, read as one word or as two halves
  typedef union packed {
    logic [2*DATA_W-1:0] word;
    struct packed {
      logic [DATA_W-1:0] hi;  // Quotient estimate from x*mu
      logic [DATA_W-1:0] lo;  // q*m, fits since q*m <= x
    } half;
  } prod_u;

endpackage : barrett_pkg

/* barrett_top.f */
barrett_pkg.sv
barrett_op_if.sv
mul_pipe.sv
barrett_in_port.sv
barrett_core.sv
barrett_out_port.sv
barrett_top.sv
tb_barrett_top.sv

/* barrett_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Barrett reduction unit top, r = x mod m
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module barrett_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  logic [barrett_pkg::DATA_W-1:0] x_i,
  input  logic [barrett_pkg::DATA_W-1:0] m_i,
  input  logic [barrett_pkg::DATA_W-1:0] mu_i,
  output logic                           ack_o,
  output logic                           res_req_o,
  input  logic                           res_ack_i,
  output logic [barrett_pkg::DATA_W-1:0] res_o
);

  barrett_op_if op_if ();

  logic                           pop;        // FIFO entry consumed
  logic                           res_valid;  // Core result strobe
  logic [barrett_pkg::DATA_W-1:0] res_data;

  barrett_in_port u_in_port (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (req_i),
    .x_i    (x_i),
    .m_i    (m_i),
    .mu_i   (mu_i),
    .pop_i  (pop),
    .ack_o  (ack_o),
    .op     (op_if.src)
  );

  barrett_core u_core (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .op          (op_if.snk),
    .res_valid_o (res_valid),
    .res_o       (res_data)
  );

  barrett_out_port u_out_port (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .res_valid_i (res_valid),
    .res_i       (res_data),
    .res_ack_i   (res_ack_i),
    .res_req_o   (res_req_o),
    .res_o       (res_o),
    .pop_o       (pop)
  );

endmodule : barrett_top

/* mul_pipe.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Pipelined 64x64 unsigned multiplier, one issue per cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mul_pipe (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           valid_i,
  input  logic [barrett_pkg::DATA_W-1:0] a_i,
  input  logic [barrett_pkg::DATA_W-1:0] b_i,
  output logic                           valid_o,
  output barrett_pkg::prod_u             p_o
);

  logic [barrett_pkg::MUL_STAGES-1:0] vld_q;          // Valid travelling with data
  logic [barrett_pkg::DATA_W-1:0]     pp00_q, pp01_q;  // Stage 1 partial products
  logic [barrett_pkg::DATA_W-1:0]     pp10_q, pp11_q;
  logic [2*barrett_pkg::DATA_W-1:0]   base_q;          // Stage 2, hi*hi and lo*lo
  logic [barrett_pkg::DATA_W:0]       mid_q;           // Stage 2, cross terms plus carry

  // Valid chain, the only state with reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[barrett_pkg::MUL_STAGES-2:0], valid_i};
    end
  end

  assign valid_o = vld_q[barrett_pkg::MUL_STAGES-1];

  always_ff @(posedge clk_i) begin
    // Stage 1: four 32x32 products
    pp00_q <= a_i[31:0]  * b_i[31:0];
    pp01_q <= a_i[31:0]  * b_i[63:32];
    pp10_q <= a_i[63:32] * b_i[31:0];
    pp11_q <= a_i[63:32] * b_i[63:32];
    // Stage 2: outer terms concatenate, cross terms add
    base_q <= {pp11_q, pp00_q};
    mid_q  <= {1'b0, pp01_q} + {1'b0, pp10_q};
    // Stage 3: merge cross sum at bit 32
    p_o.word <= base_q + ({63'b0, mid_q} << 32);
  end

endmodule : mul_pipe

/* run.sh */
#!/usr/bin/env bash
# Build and run the Barrett reduction testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_barrett_top -f barrett_top.f -o sim_barrett \
  && ./obj_dir/sim_barrett 2>&1 | tee sim.log
grep -qx "TEST PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* tb_barrett_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Barrett unit testbench, random and edge operands, credit and handshake checks
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_barrett_top;

  localparam int TMO   = 1000;                            // Cycles allowed per wait
  localparam int DEPTH = int'(barrett_pkg::FIFO_DEPTH);  // Credit limit

  logic        clk_i, rst_ni, req_i, ack_o, res_req_o, res_ack_i;
  logic [63:0] x_i, m_i, mu_i, res_o;
  logic [63:0] exp_q [$];                     // Expected remainders, input order
  logic [31:0] lfsr_state = 32'd93453;
  logic        rst_d = 1'b0;                  // Previous-edge copies for protocol checks
  logic        ack_d = 1'b0;
  logic        req_d = 1'b0;
  logic        res_req_d = 1'b0;
  logic        res_ack_d = 1'b0;
  logic [63:0] res_o_d = '0;
  int          in_flight = 0;                 // Accepted minus delivered
  int          peak = 0;
  int          acks_total = 0;

  barrett_top UUT (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .x_i       (x_i),
    .m_i       (m_i),
    .mu_i      (mu_i),
    .ack_o     (ack_o),
    .res_req_o (res_req_o),
    .res_ack_i (res_ack_i),
    .res_o     (res_o)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;  // 100 ns period

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[62:0], lfsr_step()};
    return v;
  endfunction

  function automatic logic [63:0] rand_mod();
    logic [63:0] m;
    m = rand_bits(32);
    return (m < 64'd2) ? 64'd2 : m;  // Smallest legal modulus
  endfunction

  task automatic wait_ack(input logic level);
    int t;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (ack_o !== level && t < TMO);
    if (ack_o !== level) abort_run($sformatf("timeout waiting for ack_o to reach %0b", level));
  endtask

  task automatic wait_res_req(input logic level);
    int t;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (res_req_o !== level && t < TMO);
    if (res_req_o !== level) begin
      abort_run($sformatf("timeout waiting for res_req_o to reach %0b", level));
    end
  endtask

  // Producer side, mu = floor(2^64 / m) in wide arithmetic
  task automatic send_op(input logic [63:0] x, input logic [63:0] m);
    logic [127:0] mu_w;
    mu_w = (128'd1 << 64) / {64'd0, m};
    exp_q.push_back(x % m);
    req_i <= 1'b1;
    x_i   <= x;
    m_i   <= m;
    mu_i  <= mu_w[63:0];
    wait_ack(1'b1);
    req_i <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic send_random();
    logic [63:0] x;
    x = rand_bits(64);
    send_op(x, rand_mod());
  endtask

  // Consumer side, holds off ack for delay cycles
  task automatic recv_result(input int delay);
    logic [63:0] got;
    logic [63:0] want;
    wait_res_req(1'b1);
    got = res_o;
    assert (exp_q.size() > 0) else abort_run("result delivered with no operand outstanding");
    want = exp_q.pop_front();
    assert (got == want) else begin
      abort_run($sformatf("mismatch at %0t: res_o = 0x%h, expected 0x%h", $time, got, want));
    end
    repeat (delay) @(posedge clk_i);
    res_ack_i <= 1'b1;
    wait_res_req(1'b0);
    res_ack_i <= 1'b0;
  endtask

  task automatic run_pair(input logic [63:0] x, input logic [63:0] m);
    fork
      send_op(x, m);
      recv_result(int'(rand_bits(2)));
    join
  endtask

  // Protocol and credit monitor, all values sampled at the edge
  always @(posedge clk_i) begin
    if (!rst_ni || !rst_d) begin
      assert (!ack_o && !res_req_o) else abort_run("ack_o or res_req_o high in or after reset");
    end else begin
      if (ack_o && !ack_d) begin
        assert (req_i && req_d) else abort_run("ack_o rose while req_i was low");
        assert (in_flight < DEPTH) else abort_run("ack_o rose with every FIFO credit in use");
      end
      if (!res_req_o && res_req_d) begin
        assert (res_ack_d) else abort_run("res_req_o fell before res_ack_i rose");
      end
      if (res_req_o && res_req_d) begin
        assert (res_o == res_o_d) else begin
          abort_run($sformatf("mismatch at %0t: res_o = 0x%h, held 0x%h", $time, res_o, res_o_d));
        end
      end
    end
    rst_d      <= rst_ni;
    ack_d      <= ack_o;
    req_d      <= req_i;
    res_req_d  <= res_req_o;
    res_ack_d  <= res_ack_i;
    res_o_d    <= res_o;
    acks_total <= acks_total + int'(ack_o && !ack_d);
    in_flight  <= in_flight + int'(ack_o && !ack_d) - int'(!res_req_o && res_req_d);
    if (in_flight > peak) peak <= in_flight;
  end

  initial begin
    int          base;
    int          acks_early;
    logic [63:0] m;
    rst_ni    = 1'b0;
    req_i     = 1'b0;
    res_ack_i = 1'b0;
    x_i       = '0;
    m_i       = '0;
    mu_i      = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    fork  // Random traffic, random consumer delay
      repeat (200) send_random();
      repeat (200) recv_result(int'(rand_bits(2)));
    join
    m = rand_mod();
    run_pair(m - 64'd1, m);               // x below m
    run_pair(m * rand_bits(32), m);       // Exact multiple
    run_pair('1, m);
    run_pair(rand_bits(64), 64'd2);
    run_pair('1, 64'd2);
    run_pair(rand_bits(64), 64'hFFFF_FFFF);
    run_pair('1, 64'hFFFF_FFFF);
    fork  // Consumer stalls, producer keeps asking
      repeat (8) send_random();
      begin
        recv_result(40);
        repeat (7) recv_result(int'(rand_bits(2)));
      end
    join
    assert (peak == DEPTH) else abort_run("credit limit never reached under back-pressure");
    base = acks_total;
    acks_early = 0;
    fork  // Back-to-back requests, immediate consumer
      repeat (8) send_random();
      repeat (8) recv_result(0);
      begin
        wait_res_req(1'b1);
        acks_early = acks_total - base;
      end
    join
    assert (acks_early >= 2) else abort_run("only one operand in flight with back-to-back requests");
    repeat (4) @(posedge clk_i);
    if (exp_q.size() != 0 || in_flight != 0 || res_req_o) begin
      abort_run("results lost or left over at end of run");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule : tb_barrett_top
